// File: bench/controlUnitTests.svh
function automatic instClassT classOf(input opcodeT op, input funcT fn);
    case (op)
        opBne, opBeq, opBgz, opBlz: return clsBranch;
        opAdi, opOri, opLhi:        return clsImm;
        opLwd:                      return clsLoad;
        opSwd:                      return clsStore;
        opJmp:                      return clsJump;
        opJal:                      return clsJumpLink;
        opAlu:
        begin
            if (fn <= fnShr)
                return clsArith;
            else if (fn == fnJpr)
                return clsJumpReg;
            else if (fn == fnJrl)
                return clsJumpRegLink;
            else if (fn == fnHlt)
                return clsHalt;
        end
        default: return clsNop;
    endcase
    return clsNop;    // wwd and unknown funcs
endfunction

function automatic ctrlT expectedCtrl(input stageT st, input opcodeT op, input funcT fn);
    instClassT cls;
    ctrlT      c;
    cls     = classOf(op, fn);
    c       = '0;
    c.aluOp = aluAdd;
    case (st)
        stFetch1, stFetch2, stFetch3:
        begin
            c.memRead     = 1'b1;
            c.aluSrcB     = srcBOne;
            c.irWrite     = (st == stFetch3);
            c.aluOutWrite = (st == stFetch3);
        end
        stFetch4:
        begin
            c.pcWrite  = 1'b1;
            c.pcSource = pcSrcSeq;
            c.aluSrcB  = srcBImm;
            c.immKind  = immSigned;
        end
        stDecode:
        begin
            c.pcSource    = pcSrcSeq;
            c.aluSrcB     = srcBImm;
            c.aluOutWrite = (cls == clsBranch);
        end
        stExec1:
        begin
            c.aluSrcA = !(cls == clsJump || cls == clsJumpLink);
            case (op)
                opBne:               c.aluOp = aluBne;
                opBeq:               c.aluOp = aluBeq;
                opBgz:               c.aluOp = aluBgz;
                opBlz:               c.aluOp = aluBlz;
                opOri:               c.aluOp = aluOrr;
                opLhi:               c.aluOp = aluLhi;
                opJmp, opJal:        c.aluOp = aluJmp;
                default:             c.aluOp = aluAdd;
            endcase
            if (cls == clsArith)
            begin
                case (fn)
                    fnSub:   c.aluOp = aluSub;
                    fnAnd:   c.aluOp = aluAnd;
                    fnOrr:   c.aluOp = aluOrr;
                    fnNot:   c.aluOp = aluNot;
                    fnTcp:   c.aluOp = aluTcp;
                    fnShl:   c.aluOp = aluShl;
                    fnShr:   c.aluOp = aluShr;
                    default: c.aluOp = aluAdd;
                endcase
                c.aluSrcB = (fn >= fnShl) ? srcBOne : srcBReg;
            end
            else if (cls == clsBranch)
                c.aluSrcB = (op == opBgz || op == opBlz) ? srcBZero : srcBReg;
            else if (cls == clsJumpReg || cls == clsJumpRegLink)
                c.aluSrcB = srcBZero;
            else if (cls != clsHalt && cls != clsNop)
                c.aluSrcB = srcBImm;
            if (cls == clsImm || cls == clsLoad || cls == clsStore)
                c.immKind = immSigned;
            else if (cls == clsJump || cls == clsJumpLink)
                c.immKind = immTarget;
        end
        stExec2:
        begin
            c.pcWrite     = (cls == clsJump || cls == clsJumpLink ||
                             cls == clsJumpReg || cls == clsJumpRegLink);
            c.pcWriteCond = (cls == clsBranch);
            c.pcSource    = (cls == clsBranch) ? pcSrcSeq : pcSrcTarget;
            c.aluOutWrite = (cls == clsArith || cls == clsImm ||
                             cls == clsLoad || cls == clsStore);
        end
        stMem1:
        begin
            c.iOrD      = 1'b1;
            c.memRead   = (cls == clsLoad);
            c.storeData = (cls == clsStore);
        end
        stMem2:
        begin
            c.iOrD     = 1'b1;
            c.mdrWrite = (cls == clsLoad);
            c.memWrite = (cls == clsStore);
        end
        stWriteBack:
        begin
            if (cls == clsImm || cls == clsLoad)
                c.regDst = dstRt;
            else if (cls == clsArith)
                c.regDst = dstRd;
            else if (cls == clsJumpLink || cls == clsJumpRegLink)
                c.regDst = dstLink;
            c.regWrite = (c.regDst != dstNone);
            c.memToReg = (cls == clsLoad);
        end
        default: c.aluOp = aluAdd;    // mem wait and halt are idle
    endcase
    return c;
endfunction

task automatic buildWalk(input instClassT cls);
    walk.delete();
    walk.push_back(stFetch1);
    walk.push_back(stFetch2);
    walk.push_back(stFetch3);
    walk.push_back(stFetch4);
    if (cls != clsJump && cls != clsJumpLink)
        walk.push_back(stDecode);    // direct jumps skip decode
    walk.push_back(stExec1);
    if (cls == clsHalt)
        walk.push_back(stHalt);
    else
    begin
        walk.push_back(stExec2);
        if (cls == clsLoad || cls == clsStore)
        begin
            walk.push_back(stMem1);
            walk.push_back(stMem2);
            walk.push_back(stMem3);
            walk.push_back(stMem4);
        end
        if (cls != clsBranch && cls != clsStore)
            walk.push_back(stWriteBack);
    end
endtask

// entered at the falling edge of a stFetch1 cycle
task automatic runInstr(input opcodeT op, input funcT fn, input string name);
    regWriteAt    = 0;
    pcWriteCondAt = 0;
    pcTargetAt    = 0;
    writtenDst    = dstNone;
    buildWalk(classOf(op, fn));
    foreach (walk[i])
    begin
        checkEqual(32'(u_dut.uSequencer.stage), 32'(walk[i]),
                   $sformatf("%s cycle %0d stage", name, i + 1));
        checkEqual(32'(ctrl), 32'(expectedCtrl(walk[i], op, fn)),
                   $sformatf("%s cycle %0d ctrl", name, i + 1));
        checkEqual(32'(halted), 32'(walk[i] == stHalt),
                   $sformatf("%s cycle %0d halted", name, i + 1));
        if (ctrl.regWrite)
        begin
            regWriteAt = i + 1;
            writtenDst = ctrl.regDst;
        end
        if (ctrl.pcWriteCond)
            pcWriteCondAt = i + 1;
        if (ctrl.pcWrite && ctrl.pcSource == pcSrcTarget)
            pcTargetAt = i + 1;
        if (walk[i] != stHalt)
        begin
            @(posedge clk);
            if (walk[i] == stFetch3)
            begin
                opcode <= op;    // ir loads at the end of fetch 3
                func   <= fn;
            end
            @(negedge clk);
        end
    end
endtask

task automatic waitForFetch1();
    int n;
    n = 0;
    @(negedge clk);
    while (u_dut.uSequencer.stage != stFetch1)
    begin
        if (n >= 20)
            failRun("stFetch1 was not reached after reset");
        else
        begin
            @(negedge clk);
            n++;
        end
    end
endtask

task automatic waitForHalted();
    int n;
    n = 0;
    while (!halted)
    begin
        if (n >= 20)
            failRun("halted never went high after HLT");
        else
        begin
            @(negedge clk);
            n++;
        end
    end
endtask

task automatic applyReset();
    @(posedge clk);
    rstN <= 1'b0;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    waitForFetch1();
endtask

task automatic testArith();
    funcT fn;
    repeat (6)
    begin
        fn = funcT'($urandom % 8);
        runInstr(opAlu, fn, $sformatf("alu func %0d", fn));
        checkEqual(32'(regWriteAt), 32'd8, "alu regWrite cycle");
        checkEqual(32'(writtenDst), 32'(dstRd), "alu destination");
    end
endtask

task automatic testImmediate();
    opcodeT ops[3];
    ops = '{opAdi, opOri, opLhi};
    foreach (ops[k])
    begin
        runInstr(ops[k], fnAdd, $sformatf("imm opcode %0d", ops[k]));
        checkEqual(32'(regWriteAt), 32'd8, "imm regWrite cycle");
        checkEqual(32'(writtenDst), 32'(dstRt), "imm destination");
    end
endtask

task automatic testMemory();
    runInstr(opLwd, fnAdd, "lwd");
    checkEqual(32'(u_dut.uSequencer.stage), 32'(stFetch1), "lwd restarts fetch after 12 cycles");
    checkEqual(32'(regWriteAt), 32'd12, "lwd regWrite cycle");
    runInstr(opSwd, fnAdd, "swd");
    checkEqual(32'(u_dut.uSequencer.stage), 32'(stFetch1), "swd restarts fetch after 11 cycles");
    checkEqual(32'(regWriteAt), 32'd0, "swd writes no register");
endtask

task automatic testBranches();
    opcodeT ops[4];
    ops = '{opBne, opBeq, opBgz, opBlz};
    foreach (ops[k])
    begin
        runInstr(ops[k], fnAdd, $sformatf("branch opcode %0d", ops[k]));
        checkEqual(32'(pcWriteCondAt), 32'd7, "branch pcWriteCond cycle");
        checkEqual(32'(regWriteAt), 32'd0, "branch writes no register");
    end
endtask

task automatic testJumps();
    runInstr(opJmp, fnAdd, "jmp");
    checkEqual(32'(pcTargetAt), 32'd6, "jmp pc write cycle");
    checkEqual(32'(regWriteAt), 32'd0, "jmp writes no register");
    runInstr(opJal, fnAdd, "jal");
    checkEqual(32'(pcTargetAt), 32'd6, "jal pc write cycle");
    checkEqual(32'(writtenDst), 32'(dstLink), "jal link destination");
    runInstr(opAlu, fnJpr, "jpr");
    checkEqual(32'(pcTargetAt), 32'd7, "jpr pc write cycle");
    checkEqual(32'(regWriteAt), 32'd0, "jpr writes no register");
    runInstr(opAlu, fnJrl, "jrl");
    checkEqual(32'(pcTargetAt), 32'd7, "jrl pc write cycle");
    checkEqual(32'(writtenDst), 32'(dstLink), "jrl link destination");
endtask

task automatic testNopAndHalt();
    runInstr(opAlu, fnWwd, "wwd");
    checkEqual(32'(regWriteAt), 32'd0, "wwd writes no register");
    runInstr(opAlu, fnHlt, "hlt");
    waitForHalted();
    repeat (16)
    begin
        @(posedge clk);
        opcode <= opAdi;    // input change must not wake it
        @(negedge clk);
        checkEqual(32'(halted), 32'd1, "halted held");
        checkEqual(32'(ctrl), 32'(expectedCtrl(stHalt, opAdi, fnAdd)), "halt strobes off");
    end
    applyReset();
    runInstr(opAdi, fnAdd, "adi after reset");
endtask

// File: bench/controlUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb;
    import cpuControlPkg::*;

    logic   clk;
    logic   rstN;
    opcodeT opcode;
    funcT   func;
    ctrlT   ctrl;
    logic   halted;

    stageT  walk[$];          // predicted stages of one instruction
    int     regWriteAt;       // cycle number from 1 with 0 for never
    int     pcWriteCondAt;
    int     pcTargetAt;
    regDstT writtenDst;

    controlUnit u_dut (
        .clk    (clk),
        .rstN   (rstN),
        .opcode (opcode),
        .func   (func),
        .ctrl   (ctrl),
        .halted (halted)
    );

    always #4 clk = ~clk;    // 8 ns period

    task automatic failRun(input string reason);
        $display("Checks failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t ns: %s (got %0h, expected %0h)",
                     $time, msg, actual, expected);
            failRun("a checked value differs from its expected value");
        end
    endtask

    `include "controlUnitTests.svh"

    initial
    begin
        #100000;
        failRun("the simulation ran past its time limit");
    end

    initial
    begin
        void'($urandom(65304));
        clk    = 1'b0;
        rstN   = 1'b0;
        opcode = opAlu;
        func   = fnAdd;
        applyReset();
        testArith();
        testImmediate();
        testMemory();
        testBranches();
        testJumps();
        testNopAndHalt();
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f verilog.f --top-module controlUnitTb \
    -Mdir obj_dir -o controlUnitSim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/controlUnitSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// File: source/controlGenerator.sv
`timescale 1ns/10ps
`default_nettype none

module controlGenerator (
    input  cpuControlPkg::stageT   stage,
    input  cpuControlPkg::decodedT decoded,
    output cpuControlPkg::ctrlT    ctrl
);
    import cpuControlPkg::*;

    logic isBranch;
    logic isLoad;
    logic isStore;
    logic isDirectJump;

    assign isBranch     = (decoded.instClass == clsBranch);
    assign isLoad       = (decoded.instClass == clsLoad);
    assign isStore      = (decoded.instClass == clsStore);
    assign isDirectJump = (decoded.instClass == clsJump) ||
                          (decoded.instClass == clsJumpLink);

    always_comb
    begin
        ctrl       = '0;
        ctrl.aluOp = aluAdd;

        case (stage)
            stFetch1, stFetch2, stFetch3:
            begin
                ctrl.memRead = 1'b1;
                ctrl.aluSrcB = srcBOne;    // pc plus one
                if (stage == stFetch3)
                begin
                    ctrl.irWrite     = 1'b1;
                    ctrl.aluOutWrite = 1'b1;
                end
            end
            stFetch4:
            begin
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = pcSrcSeq;
                ctrl.aluSrcB  = srcBImm;
                ctrl.immKind  = immSigned;    // branch target precompute
            end
            stDecode:
            begin
                ctrl.pcSource    = pcSrcSeq;
                ctrl.aluSrcB     = srcBImm;
                ctrl.aluOutWrite = isBranch;    // latch branch target
            end
            stExec1:
            begin
                ctrl.aluOp   = decoded.aluOp;
                ctrl.aluSrcB = decoded.srcB;
                ctrl.immKind = decoded.immKind;
                ctrl.aluSrcA = !isDirectJump;
            end
            stExec2:
            begin
                case (decoded.instClass)
                    clsJumpReg, clsJumpRegLink, clsJump, clsJumpLink:
                    begin
                        ctrl.pcWrite  = 1'b1;
                        ctrl.pcSource = pcSrcTarget;
                    end
                    clsBranch:
                    begin
                        ctrl.pcWriteCond = 1'b1;    // taken if alu compare holds
                        ctrl.pcSource    = pcSrcSeq;
                    end
                    clsArith, clsImm, clsLoad, clsStore: ctrl.aluOutWrite = 1'b1;
                    default:                             ctrl.aluOutWrite = 1'b0;
                endcase
            end
            stMem1:
            begin
                ctrl.iOrD      = 1'b1;
                ctrl.memRead   = isLoad;
                ctrl.storeData = isStore;
            end
            stMem2:
            begin
                ctrl.iOrD     = 1'b1;
                ctrl.mdrWrite = isLoad;
                ctrl.memWrite = isStore;
            end
            stWriteBack:
            begin
                if (decoded.regDst != dstNone)
                begin
                    ctrl.regWrite = 1'b1;
                    ctrl.regDst   = decoded.regDst;
                end
                ctrl.memToReg = isLoad;
            end
            default: ctrl.aluOp = aluAdd;    // mem wait and halt stay idle
        endcase
    end

endmodule

`default_nettype wire

// File: source/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  logic                  clk,
    input  logic                  rstN,
    input  cpuControlPkg::opcodeT opcode,
    input  cpuControlPkg::funcT   func,
    output cpuControlPkg::ctrlT   ctrl,
    output logic                  halted
);
    import cpuControlPkg::*;

    decodedT decoded;
    stageT   stage;

    opcodeDecoder uDecoder (
        .opcode  (opcode),
        .func    (func),
        .decoded (decoded)
    );

    stageSequencer uSequencer (
        .clk     (clk),
        .rstN    (rstN),
        .decoded (decoded),
        .stage   (stage),
        .halted  (halted)
    );

    controlGenerator uGenerator (
        .stage   (stage),
        .decoded (decoded),
        .ctrl    (ctrl)
    );

endmodule

`default_nettype wire

// File: source/cpuControlPkg.sv
`default_nettype none

package cpuControlPkg;

    typedef logic [3:0] opcodeT;
    typedef logic [5:0] funcT;

    localparam opcodeT opBne = 4'd0;
    localparam opcodeT opBeq = 4'd1;
    localparam opcodeT opBgz = 4'd2;
    localparam opcodeT opBlz = 4'd3;
    localparam opcodeT opAdi = 4'd4;
    localparam opcodeT opOri = 4'd5;
    localparam opcodeT opLhi = 4'd6;
    localparam opcodeT opLwd = 4'd7;
    localparam opcodeT opSwd = 4'd8;
    localparam opcodeT opJmp = 4'd9;
    localparam opcodeT opJal = 4'd10;
    localparam opcodeT opAlu = 4'd15;    // register-register with op in func

    localparam funcT fnAdd = 6'd0;
    localparam funcT fnSub = 6'd1;
    localparam funcT fnAnd = 6'd2;
    localparam funcT fnOrr = 6'd3;
    localparam funcT fnNot = 6'd4;
    localparam funcT fnTcp = 6'd5;
    localparam funcT fnShl = 6'd6;
    localparam funcT fnShr = 6'd7;
    localparam funcT fnJpr = 6'd25;
    localparam funcT fnJrl = 6'd26;
    localparam funcT fnWwd = 6'd28;    // decoded as nop
    localparam funcT fnHlt = 6'd29;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOrr, aluNot, aluTcp, aluShl, aluShr, aluLhi,
        aluBne, aluBeq, aluBgz, aluBlz,
        aluJmp
    } aluOpT;

    typedef enum logic [1:0] {
        srcBReg  = 2'd0,
        srcBOne  = 2'd1,
        srcBImm  = 2'd2,
        srcBZero = 2'd3
    } srcBSelT;

    typedef enum logic [1:0] {
        immNone   = 2'd0,
        immSigned = 2'd1,    // sign-extended 8-bit field
        immTarget = 2'd2     // 12-bit jump target
    } immKindT;

    typedef enum logic [1:0] {
        dstNone = 2'd0,
        dstRt   = 2'd1,
        dstRd   = 2'd2,
        dstLink = 2'd3    // register two
    } regDstT;

    typedef enum logic {
        pcSrcTarget = 1'b0,
        pcSrcSeq    = 1'b1
    } pcSrcT;

    typedef enum logic [3:0] {
        clsArith, clsImm, clsLoad, clsStore, clsBranch,
        clsJump, clsJumpLink, clsJumpReg, clsJumpRegLink,
        clsHalt, clsNop
    } instClassT;

    typedef enum logic [3:0] {
        stFetch1, stFetch2, stFetch3, stFetch4,
        stDecode,
        stExec1, stExec2,
        stMem1, stMem2, stMem3, stMem4,
        stWriteBack,
        stHalt
    } stageT;

    typedef struct packed {
        instClassT instClass;
        aluOpT     aluOp;
        srcBSelT   srcB;
        immKindT   immKind;
        regDstT    regDst;
    } decodedT;

    typedef struct packed {
        logic    pcWrite;
        logic    pcWriteCond;
        pcSrcT   pcSource;
        logic    iOrD;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    irWrite;
        logic    mdrWrite;
        logic    aluOutWrite;
        logic    storeData;
        aluOpT   aluOp;
        logic    aluSrcA;
        srcBSelT aluSrcB;
        immKindT immKind;
        logic    regWrite;
        regDstT  regDst;
    } ctrlT;

endpackage

`default_nettype wire

// File: source/opcodeDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module opcodeDecoder (
    input  cpuControlPkg::opcodeT  opcode,
    input  cpuControlPkg::funcT    func,
    output cpuControlPkg::decodedT decoded
);
    import cpuControlPkg::*;

    always_comb
    begin
        decoded.instClass = clsNop;
        decoded.aluOp     = aluAdd;
        decoded.srcB      = srcBReg;

        case (opcode)
            opBne:
            begin
                decoded.instClass = clsBranch;
                decoded.aluOp     = aluBne;
            end
            opBeq:
            begin
                decoded.instClass = clsBranch;
                decoded.aluOp     = aluBeq;
            end
            opBgz:
            begin
                decoded.instClass = clsBranch;
                decoded.aluOp     = aluBgz;
                decoded.srcB      = srcBZero;    // compare against zero
            end
            opBlz:
            begin
                decoded.instClass = clsBranch;
                decoded.aluOp     = aluBlz;
                decoded.srcB      = srcBZero;
            end
            opAdi, opOri, opLhi:
            begin
                decoded.instClass = clsImm;
                decoded.srcB      = srcBImm;
                if (opcode == opOri)
                    decoded.aluOp = aluOrr;
                else if (opcode == opLhi)
                    decoded.aluOp = aluLhi;
            end
            opLwd, opSwd:
            begin
                decoded.instClass = (opcode == opLwd) ? clsLoad : clsStore;
                decoded.srcB      = srcBImm;    // base plus offset
            end
            opJmp, opJal:
            begin
                decoded.instClass = (opcode == opJmp) ? clsJump : clsJumpLink;
                decoded.aluOp     = aluJmp;
                decoded.srcB      = srcBImm;
            end
            opAlu:
            begin
                decoded.instClass = clsArith;
                case (func)
                    fnAdd: decoded.aluOp = aluAdd;
                    fnSub: decoded.aluOp = aluSub;
                    fnAnd: decoded.aluOp = aluAnd;
                    fnOrr: decoded.aluOp = aluOrr;
                    fnNot: decoded.aluOp = aluNot;
                    fnTcp: decoded.aluOp = aluTcp;
                    fnShl:
                    begin
                        decoded.aluOp = aluShl;
                        decoded.srcB  = srcBOne;    // shift by one
                    end
                    fnShr:
                    begin
                        decoded.aluOp = aluShr;
                        decoded.srcB  = srcBOne;
                    end
                    fnJpr, fnJrl:
                    begin
                        decoded.instClass = (func == fnJpr) ? clsJumpReg : clsJumpRegLink;
                        decoded.srcB      = srcBZero;    // pass rs through
                    end
                    fnHlt:   decoded.instClass = clsHalt;
                    default: decoded.instClass = clsNop;    // wwd and unknown
                endcase
            end
            default: decoded.instClass = clsNop;
        endcase

        case (decoded.instClass)
            clsImm, clsLoad, clsStore: decoded.immKind = immSigned;
            clsJump, clsJumpLink:      decoded.immKind = immTarget;
            default:                   decoded.immKind = immNone;
        endcase

        case (decoded.instClass)
            clsImm, clsLoad:             decoded.regDst = dstRt;
            clsArith:                    decoded.regDst = dstRd;
            clsJumpLink, clsJumpRegLink: decoded.regDst = dstLink;
            default:                     decoded.regDst = dstNone;
        endcase
    end

endmodule

`default_nettype wire

// File: source/stageSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module stageSequencer (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuControlPkg::decodedT decoded,
    output cpuControlPkg::stageT   stage,
    output logic                   halted
);
    import cpuControlPkg::*;

    stageT     nextStage;
    instClassT instClass;

    assign instClass = decoded.instClass;
    assign halted    = (stage == stHalt);

    always_comb
    begin
        case (stage)
            stFetch1: nextStage = stFetch2;
            stFetch2: nextStage = stFetch3;
            stFetch3: nextStage = stFetch4;
            stFetch4:
            begin
                // direct jumps go straight to execute
                if (instClass == clsJump || instClass == clsJumpLink)
                    nextStage = stExec1;
                else
                    nextStage = stDecode;
            end
            stDecode: nextStage = stExec1;
            stExec1:
            begin
                if (instClass == clsHalt)
                    nextStage = stHalt;
                else
                    nextStage = stExec2;
            end
            stExec2:
            begin
                if (instClass == clsBranch)
                    nextStage = stFetch1;
                else if (instClass == clsLoad || instClass == clsStore)
                    nextStage = stMem1;
                else
                    nextStage = stWriteBack;
            end
            stMem1: nextStage = stMem2;
            stMem2: nextStage = stMem3;
            stMem3: nextStage = stMem4;    // memory wait
            stMem4:
            begin
                if (instClass == clsStore)
                    nextStage = stFetch1;
                else
                    nextStage = stWriteBack;
            end
            stWriteBack: nextStage = stFetch1;
            stHalt:      nextStage = stHalt;    // held until reset
            default:     nextStage = stFetch1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            stage <= stFetch1;
        else
            stage <= nextStage;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+bench
source/cpuControlPkg.sv
source/opcodeDecoder.sv
source/stageSequencer.sv
source/controlGenerator.sv
source/controlUnit.sv
bench/controlUnitTb.sv
